// ==== Makefile ====
SIM = obj_dir/Vie_unit_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

$(SIM): build.f $(wildcard verilog/*.sv verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module ie_unit_tb

clean:
	rm -rf obj_dir

// ==== build.f ====
verilog/ie_types_pkg.sv
verilog/x86_inject_pkg.sv
verilog/idtr_regs.sv
verilog/ie_sequencer.sv
verilog/ie_packet_builder.sv
verilog/fetch_select.sv
verilog/ie_unit_top.sv
verification/tb_clock_gen.sv
verification/ie_unit_tb.sv

// ==== verification/ie_unit_tb.sv ====
module ie_unit_tb;

    import ie_types_pkg::*;
    import x86_inject_pkg::*;

    localparam int CLK_PERIOD          = 100;
    localparam int NUM_SCENARIOS       = 4;
    localparam int CYCLES_PER_SCENARIO = 40;
    localparam int ADDR_W              = 4;

    logic              clk;
    logic              arst_n;
    logic              cfg_we;
    logic [ADDR_W-1:0] cfg_addr;
    logic [31:0]       cfg_wdata;
    logic              ie_valid;
    ie_cause_e         ie_cause;
    wb_state_t         wb_state;
    logic              iretd_wb;
    logic              final_switch_wb;
    logic              rrag_stall;
    fetch_packet_t     ibuf_packet;
    fetch_packet_t     fetch_packet;
    ie_ctrl_t          ctrl;

    // what the DUT should show during the current cycle
    logic          chk_pkt;
    logic          chk_blank;
    fetch_packet_t exp_pkt;
    ie_state_e     exp_state;
    ie_ctrl_t      exp_ctrl;

    fetch_packet_t seq_pkts [0:8];
    ie_state_e     seq_states [0:8];
    logic [31:0]   idt_base;
    int            seed;
    int            stall_budget;
    int            pkt_errors;
    int            ctrl_errors;
    int            blank_errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) i_clock_gen (.clk(clk));

    ie_unit_top #(.ADDR_W(ADDR_W)) i_dut (.*);

    function automatic ie_ctrl_t ctrl_for_state(input ie_state_e s);
        ie_ctrl_t c;
        c.flush_pipe    = (s == IE_SETUP) || (s == IE_RET_FLUSH);
        c.ptc_clear     = c.flush_pipe;
        c.ld_eip        = (s == IE_IDLE) || (s == IE_JUMP) || (s == IE_RET_FAR);
        c.is_pop_eflags = (s == IE_POP_EFLAGS);
        c.servicing     = !(s inside {IE_IDLE, IE_SETUP});
        c.switching     = !(s inside {IE_IDLE, IE_IN_ISR});
        return c;
    endfunction

    assign exp_ctrl = ctrl_for_state(exp_state);

    // opcode bytes from the top, then the immediate lowest byte first
    function automatic fetch_packet_t make_packet(input logic [31:0] opcode, input int op_len,
                                                  input logic has_imm, input logic [31:0] imm);
        fetch_packet_t p;
        int            pos;
        p.bytes = '0;
        p.valid = 1'b1;
        pos     = 127;
        for (int i = op_len - 1; i >= 0; i--) begin
            p.bytes[pos -: 8] = opcode[8*i +: 8];
            pos = pos - 8;
        end
        for (int i = 0; i < 4; i++) begin
            if (has_imm) begin
                p.bytes[pos -: 8] = imm[8*i +: 8];
                pos = pos - 8;
            end
        end
        return p;
    endfunction

    function automatic logic [31:0] vector_of(input ie_cause_e cause);
        case (cause)
            IE_CAUSE_PROTECTION: return 32'd13;
            IE_CAUSE_PAGE_FAULT: return 32'd14;
            default:             return 32'd15;
        endcase
    endfunction

    a_fetch_value : assert property (@(posedge clk) disable iff (!arst_n)
        chk_pkt |-> (fetch_packet == exp_pkt))
    else begin
        pkt_errors++;
        $display("FAILED at %0t: fetch_packet %h, expected %h",
                 $time, $sampled(fetch_packet), $sampled(exp_pkt));
    end

    a_fetch_blank : assert property (@(posedge clk) disable iff (!arst_n)
        chk_blank |-> !fetch_packet.valid)
    else begin
        blank_errors++;
        $display("FAILED at %0t: fetch_packet.valid high while fetch is blanked", $time);
    end

    a_ctrl_value : assert property (@(posedge clk) disable iff (!arst_n)
        ctrl == exp_ctrl)
    else begin
        ctrl_errors++;
        $display("FAILED at %0t: ctrl %b, expected %b",
                 $time, $sampled(ctrl), $sampled(exp_ctrl));
    end

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic write_cfg(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_we    = 1'b0;
    endtask

    // walks n injected states, a packet lands on fetch one cycle after its state
    task automatic issue_packets(input int n, input int stall_from, input int stall_to);
        int          issued;
        int          stall_left;
        logic        stalled;
        logic [31:0] r;
        issued     = 0;
        stall_left = 0;
        stalled    = 1'b0;
        while (issued < n) begin
            r = $random(seed);
            if (stall_left == 0 && stall_budget > 0 && issued >= stall_from
                && issued <= stall_to && (r[1:0] == 2'b00 || !stalled)) begin
                stall_left = 1 + int'(r[3:2]) % 3;
                stalled    = 1'b1;
            end
            rrag_stall = (stall_left > 0);
            if (stall_left > 0) begin
                stall_left--;
                stall_budget--;
            end
            next_cycle();
            if (!rrag_stall) begin
                exp_pkt = seq_pkts[issued];
                chk_pkt = 1'b1;
                issued++;
            end
            exp_state = seq_states[(issued < n) ? issued : n - 1];
        end
        rrag_stall = 1'b0;
    endtask

    task automatic expect_blank(input int n);
        repeat (n) begin
            next_cycle();
            chk_pkt   = 1'b0;
            chk_blank = 1'b1;
        end
    endtask

    task automatic retire_final(input ie_state_e after);
        final_switch_wb = 1'b1;
        next_cycle();
        final_switch_wb = 1'b0;
        exp_state       = after;
    endtask

    // fetch should echo each buffer packet one cycle later
    task automatic stream_ibuf(input int n);
        fetch_packet_t p;
        for (int i = 0; i < n; i++) begin
            p.bytes     = {$random(seed), $random(seed), $random(seed), $random(seed)};
            p.valid     = 1'b1;
            ibuf_packet = p;
            next_cycle();
            chk_blank   = 1'b0;
            exp_pkt     = p;
            chk_pkt     = 1'b1;
        end
    endtask

    task automatic run_cause(input ie_cause_e cause);
        logic [31:0] r_eip;
        logic [31:0] r_flags;
        logic [31:0] r_cs;
        logic [31:0] gate;
        wb_state_t   st;
        r_eip        = $random(seed);
        r_flags      = $random(seed);
        r_cs         = $random(seed);
        gate         = idt_base + 32'd8 * vector_of(cause);
        st.eip       = r_eip;
        st.eflags    = r_flags[17:0];
        st.cs        = r_cs[15:0];
        stall_budget = 5;
        seq_pkts[0]  = make_packet(32'h68, 1, 1'b1, {16'h0, st.cs});
        seq_pkts[1]  = make_packet(32'h68, 1, 1'b1, st.eip);
        seq_pkts[2]  = make_packet(32'h68, 1, 1'b1, {14'h0, st.eflags});
        seq_pkts[3]  = make_packet(32'h668b2e, 3, 1'b1, gate);
        seq_pkts[4]  = make_packet(32'h668b3e, 3, 1'b1, gate + 32'd4);
        seq_pkts[5]  = make_packet(32'h87fd, 2, 1'b0, 32'h0);
        seq_pkts[6]  = make_packet(32'h66c1fd04, 4, 1'b0, 32'h0);
        seq_pkts[7]  = make_packet(32'h8ecd, 2, 1'b0, 32'h0);
        seq_pkts[8]  = make_packet(32'h66ffe7, 3, 1'b0, 32'h0);
        seq_states   = '{IE_PUSH_CS, IE_PUSH_EIP, IE_PUSH_EFLAGS, IE_LOAD_LO, IE_LOAD_HI,
                         IE_XCHG, IE_SAR, IE_MOV_CS, IE_JUMP};
        wb_state = st;
        ie_cause = cause;
        ie_valid = 1'b1;
        next_cycle();
        // scramble writeback so only the latched copy can match
        ie_valid  = 1'b0;
        ie_cause  = IE_CAUSE_NONE;
        wb_state  = ~st;
        exp_state = IE_SETUP;
        next_cycle();
        exp_state = IE_PUSH_CS;
        issue_packets(9, 1, 7);
        expect_blank(3);
        retire_final(IE_IN_ISR);
        stream_ibuf(4);
        iretd_wb = 1'b1;
        next_cycle();
        iretd_wb  = 1'b0;
        exp_state = IE_RET_FLUSH;
        next_cycle();
        exp_state     = IE_POP_EFLAGS;
        seq_pkts[0]   = make_packet(32'h665d, 2, 1'b0, 32'h0);
        seq_pkts[1]   = make_packet(32'hcb, 1, 1'b0, 32'h0);
        seq_states[0] = IE_POP_EFLAGS;
        seq_states[1] = IE_RET_FAR;
        issue_packets(2, 0, 1);
        expect_blank(2);
        retire_final(IE_IDLE);
        stream_ibuf(3);
    endtask

    // 40 cycles per scenario leaves room for the random stalls
    initial begin
        #(NUM_SCENARIOS * CYCLES_PER_SCENARIO * CLK_PERIOD);
        $display("watchdog expired, the test sequence did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed            = 88;
        pkt_errors      = 0;
        ctrl_errors     = 0;
        blank_errors    = 0;
        arst_n          = 1'b0;
        cfg_we          = 1'b0;
        cfg_addr        = '0;
        cfg_wdata       = '0;
        ie_valid        = 1'b0;
        ie_cause        = IE_CAUSE_NONE;
        wb_state        = '0;
        iretd_wb        = 1'b0;
        final_switch_wb = 1'b0;
        rrag_stall      = 1'b0;
        ibuf_packet     = '0;
        chk_pkt         = 1'b0;
        chk_blank       = 1'b0;
        exp_pkt         = '0;
        exp_state       = IE_IDLE;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n    = 1'b1;
        chk_blank = 1'b1;
        // unit still disabled, the strobe must be ignored
        ie_cause = IE_CAUSE_PROTECTION;
        ie_valid = 1'b1;
        next_cycle();
        ie_valid = 1'b0;
        ie_cause = IE_CAUSE_NONE;
        next_cycle();
        idt_base = $random(seed) & 32'hffff_fff8;
        write_cfg(ADDR_W'(0), idt_base);
        write_cfg(ADDR_W'(1), 32'h1);
        stream_ibuf(2);
        run_cause(IE_CAUSE_PROTECTION);
        run_cause(IE_CAUSE_PAGE_FAULT);
        run_cause(IE_CAUSE_INTERRUPT);
        $display("errors: packet %0d, control %0d, blank fetch %0d",
                 pkt_errors, ctrl_errors, blank_errors);
        if (pkt_errors + ctrl_errors + blank_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

// ==== verilog/fetch_select.sv ====
module fetch_select (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          inject_active,
    input  logic                          invalidate_fetch,
    input  logic                          rrag_stall,
    input  x86_inject_pkg::fetch_packet_t inject_packet,
    input  x86_inject_pkg::fetch_packet_t ibuf_packet,
    output x86_inject_pkg::fetch_packet_t fetch_packet
);

    import x86_inject_pkg::*;

    fetch_packet_t chosen;

    assign chosen = inject_active ? inject_packet : ibuf_packet;

    // stall wins, then the blanking after the final switch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_packet <= '0;
        end else if (!rrag_stall) begin
            if (invalidate_fetch) begin
                fetch_packet.bytes <= chosen.bytes;
                fetch_packet.valid <= 1'b0;
            end else begin
                fetch_packet <= chosen;
            end
        end
    end

endmodule

// ==== verilog/idtr_regs.sv ====
module idtr_regs #(
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cfg_we,
    input  logic [ADDR_W-1:0] cfg_addr,
    input  logic [31:0]       cfg_wdata,
    output logic [31:0]       idtr_base,
    output logic              unit_enable
);

    localparam logic [ADDR_W-1:0] ADDR_BASE   = ADDR_W'(0);
    localparam logic [ADDR_W-1:0] ADDR_ENABLE = ADDR_W'(1);

    logic wr_base;
    logic wr_enable;

    assign wr_base   = cfg_we && (cfg_addr == ADDR_BASE);
    assign wr_enable = cfg_we && (cfg_addr == ADDR_ENABLE);

    // gates are 8 bytes, keep the table aligned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idtr_base <= '0;
        end else if (wr_base) begin
            idtr_base <= {cfg_wdata[31:3], 3'b000};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unit_enable <= 1'b0;
        end else if (wr_enable) begin
            unit_enable <= cfg_wdata[0];
        end
    end

endmodule

// ==== verilog/ie_packet_builder.sv ====
module ie_packet_builder (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         ld_info,
    input  ie_types_pkg::ie_cause_e      ie_cause,
    input  logic [31:0]                  idtr_base,
    input  ie_types_pkg::wb_state_t      wb_state,
    input  x86_inject_pkg::inject_sel_e  inject_sel,
    output x86_inject_pkg::fetch_packet_t inject_packet
);

    import ie_types_pkg::*;
    import x86_inject_pkg::*;

    logic [31:0] vector;
    logic [31:0] gate_addr;
    logic [31:0] gate_addr_hi;

    logic [31:0] eip_q;
    logic [31:0] eflags_q;
    logic [31:0] cs_q;
    logic [31:0] gate_q;
    logic [31:0] gate_hi_q;

    always_comb begin
        case (ie_cause)
            IE_CAUSE_PROTECTION: vector = VEC_PROTECTION;
            IE_CAUSE_PAGE_FAULT: vector = VEC_PAGE_FAULT;
            IE_CAUSE_INTERRUPT:  vector = VEC_INTERRUPT;
            default:             vector = '0;
        endcase
    end

    // 8 bytes per gate
    assign gate_addr    = idtr_base + {vector[28:0], 3'b000};
    assign gate_addr_hi = gate_addr + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eip_q     <= '0;
            eflags_q  <= '0;
            cs_q      <= '0;
            gate_q    <= '0;
            gate_hi_q <= '0;
        end else if (ld_info) begin
            eip_q     <= wb_state.eip;
            eflags_q  <= {14'b0, wb_state.eflags};
            cs_q      <= {16'b0, wb_state.cs};
            gate_q    <= gate_addr;
            gate_hi_q <= gate_addr_hi;
        end
    end

    // opcode first, then the swapped immediate, zero fill to 16 bytes
    always_comb begin
        inject_packet.valid = 1'b1;
        case (inject_sel)
            SEL_PUSH_CS:
                inject_packet.bytes = {OP_PUSH_IMM32, byte_swap32(cs_q), 88'h0};
            SEL_PUSH_EIP:
                inject_packet.bytes = {OP_PUSH_IMM32, byte_swap32(eip_q), 88'h0};
            SEL_PUSH_EFLAGS:
                inject_packet.bytes = {OP_PUSH_IMM32, byte_swap32(eflags_q), 88'h0};
            SEL_LOAD_LO:
                inject_packet.bytes = {OP_MOV_EBP_MEM, byte_swap32(gate_q), 72'h0};
            SEL_LOAD_HI:
                inject_packet.bytes = {OP_MOV_EDI_MEM, byte_swap32(gate_hi_q), 72'h0};
            SEL_XCHG:
                inject_packet.bytes = {OP_XCHG, 112'h0};
            SEL_SAR:
                inject_packet.bytes = {OP_SAR, 96'h0};
            SEL_MOV_CS:
                inject_packet.bytes = {OP_MOV_CS, 112'h0};
            SEL_JMP:
                inject_packet.bytes = {OP_JMP, 104'h0};
            SEL_POP_EFLAGS:
                inject_packet.bytes = {OP_POP, 112'h0};
            SEL_RETF:
                inject_packet.bytes = {OP_RETF, 120'h0};
            default:
                inject_packet.bytes = '0;
        endcase
    end

    // writeback must name a real cause whenever the sequencer captures
    a_ld_info_has_cause : assert property (
        @(posedge clk) disable iff (!arst_n)
        ld_info |-> (ie_cause != IE_CAUSE_NONE)
    );

endmodule

// ==== verilog/ie_sequencer.sv ====
module ie_sequencer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       unit_enable,
    input  logic                       ie_valid,
    input  logic                       iretd_wb,
    input  logic                       final_switch_wb,
    input  logic                       rrag_stall,
    output logic                       ld_info,
    output x86_inject_pkg::inject_sel_e inject_sel,
    output logic                       inject_active,
    output logic                       invalidate_fetch,
    output ie_types_pkg::ie_ctrl_t     ctrl
);

    import ie_types_pkg::*;
    import x86_inject_pkg::*;

    ie_state_e state;
    ie_state_e state_nxt;
    logic      step;
    logic      in_final;
    logic      final_issued;

    // injected states only advance when rename/alloc can take the packet
    assign step = !rrag_stall;

    assign ld_info = (state == IE_IDLE) && ie_valid && unit_enable;

    always_comb begin
        state_nxt = state;
        case (state)
            IE_IDLE:        if (ld_info) state_nxt = IE_SETUP;
            IE_SETUP:       if (step) state_nxt = IE_PUSH_CS;
            IE_PUSH_CS:     if (step) state_nxt = IE_PUSH_EIP;
            IE_PUSH_EIP:    if (step) state_nxt = IE_PUSH_EFLAGS;
            IE_PUSH_EFLAGS: if (step) state_nxt = IE_LOAD_LO;
            IE_LOAD_LO:     if (step) state_nxt = IE_LOAD_HI;
            IE_LOAD_HI:     if (step) state_nxt = IE_XCHG;
            IE_XCHG:        if (step) state_nxt = IE_SAR;
            IE_SAR:         if (step) state_nxt = IE_MOV_CS;
            IE_MOV_CS:      if (step) state_nxt = IE_JUMP;
            // the retire strobe is a single pulse, never let a stall swallow it
            IE_JUMP:        if (final_switch_wb) state_nxt = IE_IN_ISR;
            IE_IN_ISR:      if (iretd_wb) state_nxt = IE_RET_FLUSH;
            IE_RET_FLUSH:   if (step) state_nxt = IE_POP_EFLAGS;
            IE_POP_EFLAGS:  if (step) state_nxt = IE_RET_FAR;
            IE_RET_FAR:     if (final_switch_wb) state_nxt = IE_IDLE;
            default:        state_nxt = IE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // jump / far return go out once, then fetch is blanked until retire
    assign in_final = (state == IE_JUMP) || (state == IE_RET_FAR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            final_issued <= 1'b0;
        end else if (!in_final) begin
            final_issued <= 1'b0;
        end else if (step) begin
            final_issued <= 1'b1;
        end
    end

    assign invalidate_fetch = in_final && final_issued;

    always_comb begin
        inject_sel    = SEL_PUSH_CS;
        inject_active = 1'b1;
        case (state)
            IE_PUSH_CS:     inject_sel = SEL_PUSH_CS;
            IE_PUSH_EIP:    inject_sel = SEL_PUSH_EIP;
            IE_PUSH_EFLAGS: inject_sel = SEL_PUSH_EFLAGS;
            IE_LOAD_LO:     inject_sel = SEL_LOAD_LO;
            IE_LOAD_HI:     inject_sel = SEL_LOAD_HI;
            IE_XCHG:        inject_sel = SEL_XCHG;
            IE_SAR:         inject_sel = SEL_SAR;
            IE_MOV_CS:      inject_sel = SEL_MOV_CS;
            IE_JUMP:        inject_sel = SEL_JMP;
            IE_POP_EFLAGS:  inject_sel = SEL_POP_EFLAGS;
            IE_RET_FAR:     inject_sel = SEL_RETF;
            // idle, isr and the flush cycles let the instruction buffer through
            default:        inject_active = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.flush_pipe    = (state == IE_SETUP) || (state == IE_RET_FLUSH);
        ctrl.ptc_clear     = ctrl.flush_pipe;
        ctrl.ld_eip        = (state == IE_IDLE) || in_final;
        ctrl.is_pop_eflags = (state == IE_POP_EFLAGS);
        ctrl.servicing     = (state != IE_IDLE) && (state != IE_SETUP);
        ctrl.switching     = (state != IE_IDLE) && (state != IE_IN_ISR);
    end

    // writeback can only retire the jump or far return after it went out
    a_final_after_issue : assert property (
        @(posedge clk) disable iff (!arst_n)
        final_switch_wb |-> invalidate_fetch
    );

    // only injected packets are in flight while the sequence runs
    a_no_iretd_while_injecting : assert property (
        @(posedge clk) disable iff (!arst_n)
        iretd_wb |-> !inject_active
    );

endmodule

// ==== verilog/ie_types_pkg.sv ====
package ie_types_pkg;

    // what writeback reports alongside ie_valid
    typedef enum logic [1:0] {
        IE_CAUSE_NONE       = 2'd0,
        IE_CAUSE_PROTECTION = 2'd1,
        IE_CAUSE_PAGE_FAULT = 2'd2,
        IE_CAUSE_INTERRUPT  = 2'd3
    } ie_cause_e;

    // idt slot numbers, gate sits at base + 8 * vector
    localparam logic [31:0] VEC_PROTECTION = 32'd13;
    localparam logic [31:0] VEC_PAGE_FAULT = 32'd14;
    localparam logic [31:0] VEC_INTERRUPT  = 32'd15;

    typedef enum logic [3:0] {
        IE_IDLE        = 4'd0,
        IE_SETUP       = 4'd1,
        IE_PUSH_CS     = 4'd2,
        IE_PUSH_EIP    = 4'd3,
        IE_PUSH_EFLAGS = 4'd4,
        IE_LOAD_LO     = 4'd5,
        IE_LOAD_HI     = 4'd6,
        IE_XCHG        = 4'd7,
        IE_SAR         = 4'd8,
        IE_MOV_CS      = 4'd9,
        IE_JUMP        = 4'd10,
        IE_IN_ISR      = 4'd11,
        IE_RET_FLUSH   = 4'd12,
        IE_POP_EFLAGS  = 4'd13,
        IE_RET_FAR     = 4'd14
    } ie_state_e;

    // architectural state of the faulting instruction
    typedef struct packed {
        logic [31:0] eip;
        logic [17:0] eflags;
        logic [15:0] cs;
    } wb_state_t;

    typedef struct packed {
        logic flush_pipe;
        logic ptc_clear;
        logic ld_eip;
        logic is_pop_eflags;
        logic servicing;
        logic switching;
    } ie_ctrl_t;

endpackage

// ==== verilog/ie_unit_top.sv ====
module ie_unit_top #(
    parameter int ADDR_W = 4
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          cfg_we,
    input  logic [ADDR_W-1:0]             cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    input  logic                          ie_valid,
    input  ie_types_pkg::ie_cause_e       ie_cause,
    input  ie_types_pkg::wb_state_t       wb_state,
    input  logic                          iretd_wb,
    input  logic                          final_switch_wb,
    input  logic                          rrag_stall,
    input  x86_inject_pkg::fetch_packet_t ibuf_packet,
    output x86_inject_pkg::fetch_packet_t fetch_packet,
    output ie_types_pkg::ie_ctrl_t        ctrl
);

    import x86_inject_pkg::*;

    logic [31:0]   idtr_base;
    logic          unit_enable;
    logic          ld_info;
    inject_sel_e   inject_sel;
    logic          inject_active;
    logic          invalidate_fetch;
    fetch_packet_t inject_packet;

    idtr_regs #(
        .ADDR_W (ADDR_W)
    ) i_idtr_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .idtr_base   (idtr_base),
        .unit_enable (unit_enable)
    );

    ie_sequencer i_ie_sequencer (
        .clk              (clk),
        .arst_n           (arst_n),
        .unit_enable      (unit_enable),
        .ie_valid         (ie_valid),
        .iretd_wb         (iretd_wb),
        .final_switch_wb  (final_switch_wb),
        .rrag_stall       (rrag_stall),
        .ld_info          (ld_info),
        .inject_sel       (inject_sel),
        .inject_active    (inject_active),
        .invalidate_fetch (invalidate_fetch),
        .ctrl             (ctrl)
    );

    ie_packet_builder i_ie_packet_builder (
        .clk           (clk),
        .arst_n        (arst_n),
        .ld_info       (ld_info),
        .ie_cause      (ie_cause),
        .idtr_base     (idtr_base),
        .wb_state      (wb_state),
        .inject_sel    (inject_sel),
        .inject_packet (inject_packet)
    );

    fetch_select i_fetch_select (
        .clk              (clk),
        .arst_n           (arst_n),
        .inject_active    (inject_active),
        .invalidate_fetch (invalidate_fetch),
        .rrag_stall       (rrag_stall),
        .inject_packet    (inject_packet),
        .ibuf_packet      (ibuf_packet),
        .fetch_packet     (fetch_packet)
    );

endmodule

// ==== verilog/x86_inject_pkg.sv ====
package x86_inject_pkg;

    // first instruction byte lives in bytes[127:120]
    typedef struct packed {
        logic [127:0] bytes;
        logic         valid;
    } fetch_packet_t;

    typedef enum logic [3:0] {
        SEL_PUSH_CS     = 4'd0,
        SEL_PUSH_EIP    = 4'd1,
        SEL_PUSH_EFLAGS = 4'd2,
        SEL_LOAD_LO     = 4'd3,
        SEL_LOAD_HI     = 4'd4,
        SEL_XCHG        = 4'd5,
        SEL_SAR         = 4'd6,
        SEL_MOV_CS      = 4'd7,
        SEL_JMP         = 4'd8,
        SEL_POP_EFLAGS  = 4'd9,
        SEL_RETF        = 4'd10
    } inject_sel_e;

    localparam logic [7:0]  OP_PUSH_IMM32  = 8'h68;
    // mov ebp / edi from a 32-bit absolute address
    localparam logic [23:0] OP_MOV_EBP_MEM = 24'h668b2e;
    localparam logic [23:0] OP_MOV_EDI_MEM = 24'h668b3e;
    localparam logic [15:0] OP_XCHG        = 16'h87fd;
    localparam logic [31:0] OP_SAR         = 32'h66c1fd04;
    localparam logic [15:0] OP_MOV_CS      = 16'h8ecd;
    localparam logic [23:0] OP_JMP         = 24'h66ffe7;
    // pop into ebp, decode treats it as an eflags load
    localparam logic [15:0] OP_POP         = 16'h665d;
    localparam logic [7:0]  OP_RETF        = 8'hcb;

    // immediates are stored little endian in the byte stream
    function automatic logic [31:0] byte_swap32(input logic [31:0] value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

endpackage
